//--- filelist.f
src/pcim_pkg.sv
src/ocl_cfg_regs.sv
src/fsb_wr_gen.sv
src/trace_fifo.sv
src/trace_wr_gen.sv
src/pcim_wr_arb.sv
src/cl_to_pcim_top.sv
test/tb_clk_gen.sv
test/pcim_checker.sv
test/tb_top.sv

//--- test/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  import pcim_pkg::*;

  typedef enum logic [2:0] {
    K_CFG,
    K_FSB,
    K_TRACE,
    K_FLR,
    K_IDLE
  } kind_e;

  typedef struct packed {
    kind_e     kind;
    cfg_addr_t idx;
    data_t     data;
    logic      last;
  } stim_t;

  logic        clk;
  logic        arst_n;
  logic        flr_i;
  logic        cfg_wr_valid_i;
  cfg_wr_t     cfg_wr_i;
  logic        fsb_valid_i;
  fsb_word_t   fsb_data_i;
  logic        fsb_yumi_o;
  logic        trace_valid_i;
  trace_beat_t trace_i;
  logic        trace_ready_o;
  logic        pcim_wvalid_o;
  wr_req_t     pcim_wr_o;
  logic        pcim_wready_i;
  logic        blocked;

  stim_t       stim_q[$];
  logic [31:0] rng = 32'h140d_2476;
  addr_t       fsb_base_m;
  addr_t       trace_base_m;
  int          fsb_count;
  int          trace_count;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  cl_to_pcim_top #(
    .TRACE_DEPTH (8)
  ) u_dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .flr_i          (flr_i),
    .cfg_wr_valid_i (cfg_wr_valid_i),
    .cfg_wr_i       (cfg_wr_i),
    .fsb_valid_i    (fsb_valid_i),
    .fsb_data_i     (fsb_data_i),
    .fsb_yumi_o     (fsb_yumi_o),
    .trace_valid_i  (trace_valid_i),
    .trace_i        (trace_i),
    .trace_ready_o  (trace_ready_o),
    .pcim_wvalid_o  (pcim_wvalid_o),
    .pcim_wr_o      (pcim_wr_o),
    .pcim_wready_i  (pcim_wready_i)
  );

  pcim_checker u_chk (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .blocked_i     (blocked),
    .fsb_yumi_i    (fsb_yumi_o),
    .trace_ready_i (trace_ready_o),
    .pcim_wvalid_i (pcim_wvalid_o),
    .pcim_wr_i     (pcim_wr_o),
    .pcim_wready_i (pcim_wready_i)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t next_data();
    logic [31:0] hi;
    rng = lcg_next(rng);
    hi  = rng;
    rng = lcg_next(rng);
    return {hi, rng};
  endfunction

  task automatic add_stim(input kind_e kind, input cfg_addr_t idx, input data_t data,
                          input logic last);
    stim_t s;
    s.kind = kind;
    s.idx  = idx;
    s.data = data;
    s.last = last;
    stim_q.push_back(s);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic build_stim();
    int i;
    add_stim(K_CFG, REG_FSB_BASE, 64'h1000_0000, 1'b0);
    add_stim(K_CFG, REG_TRACE_BASE, 64'h2004_0000, 1'b0);
    add_stim(K_CFG, REG_ENABLE, 64'h3, 1'b0);
    for (i = 0; i < 4; i++) add_stim(K_FSB, '0, next_data(), 1'b0);
    for (i = 0; i < 4; i++) add_stim(K_TRACE, '0, next_data(), i == 3);
    // both sources competing at the arbiter
    for (i = 0; i < 8; i++) begin
      add_stim(K_FSB, '0, next_data(), 1'b0);
      add_stim(K_TRACE, '0, next_data(), (i % 2) == 1);
    end
    // long enough to fill the trace FIFO
    for (i = 0; i < 16; i++) add_stim(K_TRACE, '0, next_data(), (i % 4) == 3);
    add_stim(K_IDLE, '0, 64'd5, 1'b0);
    add_stim(K_FLR, '0, '0, 1'b0);
    add_stim(K_CFG, REG_FSB_BASE, 64'h3000_0100, 1'b0);
    add_stim(K_CFG, REG_ENABLE, 64'h3, 1'b0);
    for (i = 0; i < 3; i++) begin
      add_stim(K_FSB, '0, next_data(), 1'b0);
      add_stim(K_TRACE, '0, next_data(), i == 2);
    end
  endtask

  task automatic wait_drain();
    while (u_chk.pending() != 0) @(negedge clk);
  endtask

  // offer words that must be refused
  task automatic offer_blocked(input int cycles);
    blocked       = 1'b1;
    fsb_valid_i   = 1'b1;
    trace_valid_i = 1'b1;
    repeat (cycles) @(negedge clk);
    fsb_valid_i   = 1'b0;
    trace_valid_i = 1'b0;
    blocked       = 1'b0;
  endtask

  task automatic apply_stim(input stim_t e);
    wr_req_t want;
    case (e.kind)
      K_CFG: begin
        wait_drain();
        cfg_wr_valid_i = 1'b1;
        cfg_wr_i.addr  = e.idx;
        cfg_wr_i.data  = addr_t'(e.data);
        if (e.idx == REG_FSB_BASE) fsb_base_m = addr_t'(e.data);
        if (e.idx == REG_TRACE_BASE) trace_base_m = addr_t'(e.data);
        @(negedge clk);
        cfg_wr_valid_i = 1'b0;
      end
      K_FSB: begin
        fsb_valid_i = 1'b1;
        fsb_data_i  = fsb_word_t'(e.data);
        @(posedge clk);
        while (!fsb_yumi_o) @(posedge clk);
        want.addr = fsb_base_m + addr_t'(fsb_count * 8);
        want.data = data_t'(fsb_word_t'(e.data));
        want.src  = SRC_FSB;
        want.last = 1'b1;
        u_chk.expect_write(want);
        fsb_count++;
        @(negedge clk);
        fsb_valid_i = 1'b0;
      end
      K_TRACE: begin
        trace_valid_i = 1'b1;
        trace_i.data  = e.data;
        trace_i.last  = e.last;
        @(posedge clk);
        while (!trace_ready_o) @(posedge clk);
        want.addr = trace_base_m + addr_t'(trace_count * 8);
        want.data = e.data;
        want.src  = SRC_TRACE;
        want.last = e.last;
        u_chk.expect_write(want);
        trace_count++;
        @(negedge clk);
        trace_valid_i = 1'b0;
      end
      K_FLR: begin
        wait_drain();
        flr_i = 1'b1;
        @(negedge clk);
        flr_i       = 1'b0;
        fsb_count   = 0;
        trace_count = 0;
        offer_blocked(4);
      end
      default: begin
        repeat (int'(e.data[7:0])) @(negedge clk);
      end
    endcase
  endtask

  task automatic end_run(input logic timed_out);
    $display("summary: checks=%0d errors=%0d writes=%0d timeout=%0d",
             u_chk.check_cnt, u_chk.error_cnt, u_chk.write_cnt, timed_out);
    if (timed_out || u_chk.error_cnt != 0) begin
      $display("test failed");
    end else begin
      $display("test passed");
    end
    $finish;
  endtask

  // host back-pressure
  initial begin : ready_drive
    pcim_wready_i = 1'b0;
    forever begin
      @(negedge clk);
      rng           = lcg_next(rng);
      pcim_wready_i = rng[16];
    end
  end

  initial begin : watchdog
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run still busy after %0d cycles", cycle_limit);
    end_run(1'b1);
  end

  initial begin : main
    int drain_cycles;
    flr_i          = 1'b0;
    cfg_wr_valid_i = 1'b0;
    cfg_wr_i       = '0;
    fsb_valid_i    = 1'b0;
    fsb_data_i     = '0;
    trace_valid_i  = 1'b0;
    trace_i        = '0;
    blocked        = 1'b0;
    fsb_base_m     = '0;
    trace_base_m   = '0;
    fsb_count      = 0;
    trace_count    = 0;
    build_stim();
    cycle_limit = 40 * stim_q.size() + 200;
    @(posedge arst_n);
    @(negedge clk);
    // both sources still disabled
    offer_blocked(6);
    foreach (stim_q[i]) apply_stim(stim_q[i]);
    // bounded wait for the last writes to land
    drain_cycles = 0;
    while (u_chk.pending() != 0 && drain_cycles < 100) begin
      @(negedge clk);
      drain_cycles++;
    end
    repeat (10) @(negedge clk);
    u_chk.final_check();
    end_run(1'b0);
  end

endmodule

//--- test/pcim_checker.sv
`timescale 1ns/1ps

module pcim_checker (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              blocked_i,
  input  logic              fsb_yumi_i,
  input  logic              trace_ready_i,
  input  logic              pcim_wvalid_i,
  input  pcim_pkg::wr_req_t pcim_wr_i,
  input  logic              pcim_wready_i
);

  import pcim_pkg::*;

  wr_req_t fsb_q[$];
  wr_req_t trace_q[$];

  int check_cnt = 0;
  int error_cnt = 0;
  int write_cnt = 0;

  logic    prev_valid = 1'b0;
  logic    prev_ready = 1'b0;
  wr_req_t prev_wr;

  task automatic expect_write(input wr_req_t req);
    if (req.src == SRC_FSB) begin
      fsb_q.push_back(req);
    end else begin
      trace_q.push_back(req);
    end
  endtask

  function automatic int pending();
    return fsb_q.size() + trace_q.size();
  endfunction

  task automatic compare_field(input string name, input logic [127:0] got,
                               input logic [127:0] want);
    check_cnt++;
    if (got !== want) begin
      error_cnt++;
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, want);
    end
  endtask

  task automatic final_check();
    if (pending() != 0) begin
      error_cnt++;
      $display("expected writes never seen on the host port: fsb %0d, trace %0d",
               fsb_q.size(), trace_q.size());
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // host port monitor
  // ~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk_i) begin
    wr_req_t want;
    if (!arst_n_i) begin
      compare_field("pcim_wvalid_o", pcim_wvalid_i, 1'b0);
      compare_field("fsb_yumi_o", fsb_yumi_i, 1'b0);
      compare_field("trace_ready_o", trace_ready_i, 1'b0);
      prev_valid = 1'b0;
    end else begin
      // a stalled write must not move
      if (prev_valid && !prev_ready) begin
        compare_field("pcim_wvalid_o", pcim_wvalid_i, 1'b1);
        compare_field("pcim_wr_o", pcim_wr_i, prev_wr);
      end
      if (blocked_i) begin
        compare_field("fsb_yumi_o", fsb_yumi_i, 1'b0);
        compare_field("trace_ready_o", trace_ready_i, 1'b0);
        compare_field("pcim_wvalid_o", pcim_wvalid_i, 1'b0);
      end
      if (pcim_wvalid_i && pcim_wready_i) begin
        write_cnt++;
        if (pcim_wr_i.src == SRC_FSB && fsb_q.size() == 0) begin
          error_cnt++;
          $display("unexpected fsb write at t=%0t to %h", $time, pcim_wr_i.addr);
        end else if (pcim_wr_i.src == SRC_TRACE && trace_q.size() == 0) begin
          error_cnt++;
          $display("unexpected trace write at t=%0t to %h", $time, pcim_wr_i.addr);
        end else begin
          want = (pcim_wr_i.src == SRC_FSB) ? fsb_q.pop_front() : trace_q.pop_front();
          compare_field("pcim_wr_o.addr", pcim_wr_i.addr, want.addr);
          compare_field("pcim_wr_o.data", pcim_wr_i.data, want.data);
          compare_field("pcim_wr_o.last", pcim_wr_i.last, want.last);
        end
      end
      prev_valid = pcim_wvalid_i;
      prev_ready = pcim_wready_i;
      prev_wr    = pcim_wr_i;
    end
  end

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release lands on a falling edge
  initial begin
    arst_n_o = 1'b0;
    #(PERIOD_NS * RESET_CYCLES);
    arst_n_o = 1'b1;
  end

endmodule

//--- src/cl_to_pcim_top.sv
`timescale 1ns/1ps

module cl_to_pcim_top #(
  parameter int TRACE_DEPTH = 8
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flr_i,
  input  logic                  cfg_wr_valid_i,
  input  pcim_pkg::cfg_wr_t     cfg_wr_i,
  input  logic                  fsb_valid_i,
  input  pcim_pkg::fsb_word_t   fsb_data_i,
  output logic                  fsb_yumi_o,
  input  logic                  trace_valid_i,
  input  pcim_pkg::trace_beat_t trace_i,
  output logic                  trace_ready_o,
  output logic                  pcim_wvalid_o,
  output pcim_pkg::wr_req_t     pcim_wr_o,
  input  logic                  pcim_wready_i
);

  import pcim_pkg::*;

  addr_t fsb_base;
  addr_t trace_base;
  logic  fsb_en;
  logic  trace_en;

  logic        fifo_full;
  logic        fifo_empty;
  logic        fifo_pop;
  trace_beat_t fifo_data;

  // index 0 is fsb and index 1 is trace, matching the src ids
  logic [1:0]        req_valid;
  wr_req_t [1:0]     req;
  logic [1:0]        grant;

  assign trace_ready_o = !fifo_full && trace_en;

  ocl_cfg_regs u_cfg_regs (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .flr_i          (flr_i),
    .cfg_wr_valid_i (cfg_wr_valid_i),
    .cfg_wr_i       (cfg_wr_i),
    .fsb_base_o     (fsb_base),
    .trace_base_o   (trace_base),
    .fsb_en_o       (fsb_en),
    .trace_en_o     (trace_en)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // command source
  // ~~~~~~~~~~~~~~~~~~~~
  fsb_wr_gen u_fsb_gen (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .flr_i       (flr_i),
    .en_i        (fsb_en),
    .base_i      (fsb_base),
    .fsb_valid_i (fsb_valid_i),
    .fsb_data_i  (fsb_data_i),
    .fsb_yumi_o  (fsb_yumi_o),
    .req_valid_o (req_valid[SRC_FSB]),
    .req_o       (req[SRC_FSB]),
    .grant_i     (grant[SRC_FSB])
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // trace source
  // ~~~~~~~~~~~~~~~~~~~~
  trace_fifo #(
    .DEPTH (TRACE_DEPTH)
  ) u_trace_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .push_i      (trace_valid_i && trace_ready_o),
    .push_data_i (trace_i),
    .pop_i       (fifo_pop),
    .pop_data_o  (fifo_data),
    .full_o      (fifo_full),
    .empty_o     (fifo_empty)
  );

  trace_wr_gen u_trace_gen (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flr_i        (flr_i),
    .base_i       (trace_base),
    .fifo_empty_i (fifo_empty),
    .fifo_data_i  (fifo_data),
    .fifo_pop_o   (fifo_pop),
    .req_valid_o  (req_valid[SRC_TRACE]),
    .req_o        (req[SRC_TRACE]),
    .grant_i      (grant[SRC_TRACE])
  );

  pcim_wr_arb u_arb (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_valid_i   (req_valid),
    .req_i         (req),
    .grant_o       (grant),
    .pcim_wvalid_o (pcim_wvalid_o),
    .pcim_wr_o     (pcim_wr_o),
    .pcim_wready_i (pcim_wready_i)
  );

endmodule

//--- src/pcim_wr_arb.sv
`timescale 1ns/1ps

module pcim_wr_arb (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [1:0]              req_valid_i,
  input  pcim_pkg::wr_req_t [1:0] req_i,
  output logic [1:0]              grant_o,
  output logic                    pcim_wvalid_o,
  output pcim_pkg::wr_req_t       pcim_wr_o,
  input  logic                    pcim_wready_i
);

  import pcim_pkg::*;

  logic slot_free;
  src_t last_src_q;
  src_t prefer;
  src_t sel;

  // slot can take a new write when empty or emptying now
  assign slot_free = !pcim_wvalid_o || pcim_wready_i;
  assign prefer    = (last_src_q == SRC_FSB) ? SRC_TRACE : SRC_FSB;
  assign sel       = grant_o[SRC_TRACE] ? SRC_TRACE : SRC_FSB;

  // ~~~~~~~~~~~~~~~~~~~~
  // round robin pick
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    grant_o = '0;
    if (slot_free) begin
      if (&req_valid_i) begin
        grant_o[prefer] = 1'b1;
      end else begin
        // at most one requester here
        grant_o = req_valid_i;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // output slot
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pcim_wvalid_o <= 1'b0;
      last_src_q    <= SRC_TRACE;
    end else if (|grant_o) begin
      pcim_wvalid_o <= 1'b1;
      last_src_q    <= sel;
    end else if (pcim_wready_i) begin
      pcim_wvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|grant_o) pcim_wr_o <= req_i[sel];
  end

  a_grant_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) $onehot0(grant_o)
  );

endmodule

//--- src/trace_wr_gen.sv
`timescale 1ns/1ps

module trace_wr_gen (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  flr_i,
  input  pcim_pkg::addr_t       base_i,
  input  logic                  fifo_empty_i,
  input  pcim_pkg::trace_beat_t fifo_data_i,
  output logic                  fifo_pop_o,
  output logic                  req_valid_o,
  output pcim_pkg::wr_req_t     req_o,
  input  logic                  grant_i
);

  import pcim_pkg::*;

  gen_state_e state_q;
  addr_t      offset_q;

  // beats already in the FIFO still drain after flr
  assign fifo_pop_o  = !fifo_empty_i && !flr_i && (state_q == IDLE);
  assign req_valid_o = (state_q == REQ);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      offset_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (fifo_pop_o) state_q <= REQ;
        REQ:  if (grant_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
      if (flr_i) begin
        offset_q <= '0;
      end else if (fifo_pop_o) begin
        offset_q <= offset_q + addr_t'(DATA_BYTES);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      req_o.addr <= base_i + offset_q;
      req_o.data <= fifo_data_i.data;
      req_o.src  <= SRC_TRACE;
      // tlast passes through untouched
      req_o.last <= fifo_data_i.last;
    end
  end

  a_grant_needs_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    grant_i |-> req_valid_o
  );

endmodule

//--- src/trace_fifo.sv
`timescale 1ns/1ps

module trace_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  push_i,
  input  pcim_pkg::trace_beat_t push_data_i,
  input  logic                  pop_i,
  output pcim_pkg::trace_beat_t pop_data_o,
  output logic                  full_o,
  output logic                  empty_o
);

  import pcim_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  trace_beat_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;

  assign full_o     = (count_q == (PTR_W+1)'(DEPTH));
  assign empty_o    = (count_q == '0);
  assign pop_data_o = mem[rd_ptr_q];

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr_q] <= push_data_i;
  end

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) push_i |-> !full_o
  );
  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) pop_i |-> !empty_o
  );

endmodule

//--- src/fsb_wr_gen.sv
`timescale 1ns/1ps

module fsb_wr_gen (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                flr_i,
  input  logic                en_i,
  input  pcim_pkg::addr_t     base_i,
  input  logic                fsb_valid_i,
  input  pcim_pkg::fsb_word_t fsb_data_i,
  output logic                fsb_yumi_o,
  output logic                req_valid_o,
  output pcim_pkg::wr_req_t   req_o,
  input  logic                grant_i
);

  import pcim_pkg::*;

  gen_state_e state_q;
  addr_t      offset_q;

  // take a word only into an empty holding register
  assign fsb_yumi_o  = en_i && fsb_valid_i && !flr_i && (state_q == IDLE);
  assign req_valid_o = (state_q == REQ);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      offset_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (fsb_yumi_o) state_q <= REQ;
        REQ:  if (grant_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
      if (flr_i) begin
        offset_q <= '0;
      end else if (fsb_yumi_o) begin
        offset_q <= offset_q + addr_t'(DATA_BYTES);
      end
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (fsb_yumi_o) begin
      req_o.addr <= base_i + offset_q;
      req_o.data <= data_t'(fsb_data_i);
      req_o.src  <= SRC_FSB;
      // every command word is a complete write
      req_o.last <= 1'b1;
    end
  end

  a_grant_needs_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    grant_i |-> req_valid_o
  );

endmodule

//--- src/ocl_cfg_regs.sv
`timescale 1ns/1ps

module ocl_cfg_regs (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             flr_i,
  input  logic             cfg_wr_valid_i,
  input  pcim_pkg::cfg_wr_t cfg_wr_i,
  output pcim_pkg::addr_t  fsb_base_o,
  output pcim_pkg::addr_t  trace_base_o,
  output logic             fsb_en_o,
  output logic             trace_en_o
);

  import pcim_pkg::*;

  // base addresses survive flr, only the enables drop
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fsb_base_o   <= '0;
      trace_base_o <= '0;
      fsb_en_o     <= 1'b0;
      trace_en_o   <= 1'b0;
    end else if (flr_i) begin
      fsb_en_o   <= 1'b0;
      trace_en_o <= 1'b0;
    end else if (cfg_wr_valid_i) begin
      case (cfg_wr_i.addr)
        REG_FSB_BASE:   fsb_base_o   <= cfg_wr_i.data;
        REG_TRACE_BASE: trace_base_o <= cfg_wr_i.data;
        REG_ENABLE: begin
          fsb_en_o   <= cfg_wr_i.data[EN_FSB_BIT];
          trace_en_o <= cfg_wr_i.data[EN_TRACE_BIT];
        end
        default: ;
      endcase
    end
  end

  // the host side never targets the unmapped slot
  a_cfg_idx_mapped: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cfg_wr_valid_i |-> (cfg_wr_i.addr != 2'd3)
  );

endmodule

//--- src/pcim_pkg.sv
package pcim_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // widths and basic types
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 64;
  localparam int FSB_WIDTH  = 40;
  localparam int DATA_BYTES = 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [FSB_WIDTH-1:0]  fsb_word_t;
  typedef logic [1:0]            cfg_addr_t;
  typedef logic                  src_t;

  // register map
  localparam cfg_addr_t REG_FSB_BASE   = 2'd0;
  localparam cfg_addr_t REG_TRACE_BASE = 2'd1;
  localparam cfg_addr_t REG_ENABLE     = 2'd2;

  // bit positions inside the enable register
  localparam int EN_FSB_BIT   = 0;
  localparam int EN_TRACE_BIT = 1;

  localparam src_t SRC_FSB   = 1'b0;
  localparam src_t SRC_TRACE = 1'b1;

  // ~~~~~~~~~~~~~~~~~~~~
  // bundles
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    cfg_addr_t addr;
    addr_t     data;
  } cfg_wr_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } trace_beat_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
    src_t  src;
    logic  last;
  } wr_req_t;

  typedef enum logic {
    IDLE,
    REQ
  } gen_state_e;

endpackage
